//--- Bender.yml
package:
  name: md_system

sources:
  - verilog/md_bus_pkg.sv
  - verilog/md_clock_enables.sv
  - verilog/md_addr_decode.sv
  - verilog/md_bank_mapper.sv
  - verilog/md_rom_port.sv
  - verilog/md_work_ram.sv
  - verilog/md_bus_fsm.sv
  - verilog/md_system.sv
  - target: test
    files:
      - bench/md_bus_checker.sv
      - bench/tb_md_system.sv

//--- bench/md_bus_checker.sv
`timescale 1ns/1ps

module md_bus_checker
	import md_bus_pkg::*;
(
	input logic        MCLK,
	input logic        reset,
	input logic        cpu_done,
	input logic        dma_done,
	input bus_data_t   rdata,
	input logic        rom_req,
	input logic [23:0] rom_addr,
	input logic        cpu_ce_p,
	input logic        cpu_ce_n,
	input logic        fm_ce,
	input logic        psg_ce
);

	// Bit 16 marks a DMA result
	logic [16:0] done_q [$];
	logic [23:0] addr_q [$];
	logic        last_req;
	int          seen;
	int          cpu_cnt;
	int          cpu_gap;
	int          cpu_n_off;
	int          cpu_pulses;
	int          fm_cnt;
	int          fm_pulses;
	int          psg_cnt;
	int          psg_pulses;
	int          data_errors;
	int          addr_errors;
	int          ce_errors;
	int          period_errors;
	int          other_errors;

	task automatic expect_done(input logic is_dma, input bus_data_t value);
		done_q.push_back({is_dma, value});
	endtask

	task automatic expect_rom_addr(input logic [23:0] wa);
		addr_q.push_back(wa);
	endtask

	task automatic note_failure(input string msg);
		$display("%s", msg);
		other_errors++;
	endtask

	task automatic compare_cpu_gap(input int expected, input logic [1:0] t);
		int expected_n;
		// The n phase sits 3, 1 or 0 cycles into a 7, 4 or 2 cycle period
		case (expected)
			7:       expected_n = 3;
			4:       expected_n = 1;
			default: expected_n = 0;
		endcase
		if (cpu_gap != expected) begin
			$display("ERROR %0t: cpu_ce_p spacing %0d with turbo %0d, expected %0d",
				$time, cpu_gap, t, expected);
			period_errors++;
		end
		if (cpu_n_off != expected_n) begin
			$display("ERROR %0t: cpu_ce_n %0d cycles after cpu_ce_p with turbo %0d, expected %0d",
				$time, cpu_n_off, t, expected_n);
			ce_errors++;
		end
	endtask

	function automatic int error_total();
		return data_errors + addr_errors + ce_errors + period_errors + other_errors;
	endfunction

	task automatic print_summary();
		if (done_q.size() != 0) begin
			$display("%0d accesses never finished", done_q.size());
			other_errors++;
		end
		if (addr_q.size() != 0) begin
			$display("%0d ROM reads never reached the ROM port", addr_q.size());
			other_errors++;
		end
		if (fm_pulses < 2 || psg_pulses < 2) begin
			$display("The FM or PSG enable did not keep pulsing");
			ce_errors++;
		end
		$display("Error counts: data %0d, address %0d, enables %0d, period %0d, other %0d",
			data_errors, addr_errors, ce_errors, period_errors, other_errors);
	endtask

	// ------------------------------------------------------------------------
	// DUT outputs sampled on the falling edge
	// ------------------------------------------------------------------------

	always @(negedge MCLK) begin : watch
		logic [16:0] e;
		logic [23:0] a;
		if (reset) begin
			seen       <= 0;
			cpu_cnt    <= 0;
			cpu_n_off  <= -1;
			cpu_pulses <= 0;
			fm_cnt     <= 0;
			fm_pulses  <= 0;
			psg_cnt    <= 0;
			psg_pulses <= 0;
			last_req   <= rom_req;
		end else begin
			if (cpu_done || dma_done) begin
				seen <= seen + 1;
				if (done_q.size() == 0) begin
					$display("A done strobe came at %0t with no access outstanding", $time);
					other_errors++;
				end else begin
					e = done_q.pop_front();
					if (e[16] != dma_done) begin
						$display("ERROR %0t: done from the wrong master, dma_done %b", $time,
							dma_done);
						data_errors++;
					end else if (rdata !== e[15:0]) begin
						$display("ERROR %0t: rdata %h, expected %h", $time, rdata, e[15:0]);
						data_errors++;
					end
				end
			end

			// A toggle on rom_req starts a ROM read
			if (rom_req !== last_req) begin
				if (addr_q.size() == 0) begin
					$display("The ROM port started a read at %0t that nobody asked for", $time);
					other_errors++;
				end else begin
					a = addr_q.pop_front();
					if (rom_addr !== a) begin
						$display("ERROR %0t: rom_addr %h, expected %h", $time, rom_addr, a);
						addr_errors++;
					end
				end
			end
			last_req <= rom_req;

			if (cpu_ce_p) begin
				cpu_gap    <= cpu_cnt + 1;
				cpu_cnt    <= 0;
				cpu_pulses <= cpu_pulses + 1;
			end else begin
				cpu_cnt <= cpu_cnt + 1;
			end

			// Distance of the n phase from the last p phase
			if (cpu_ce_n) begin
				cpu_n_off <= cpu_ce_p ? 0 : cpu_cnt + 1;
			end

			if (fm_ce) begin
				if (fm_pulses > 0 && fm_cnt + 1 != 7) begin
					$display("ERROR %0t: fm_ce spacing %0d, expected 7", $time, fm_cnt + 1);
					ce_errors++;
				end
				fm_cnt    <= 0;
				fm_pulses <= fm_pulses + 1;
			end else begin
				fm_cnt <= fm_cnt + 1;
			end

			if (psg_ce) begin
				if (psg_pulses > 0 && psg_cnt + 1 != 15) begin
					$display("ERROR %0t: psg_ce spacing %0d, expected 15", $time, psg_cnt + 1);
					ce_errors++;
				end
				psg_cnt    <= 0;
				psg_pulses <= psg_pulses + 1;
			end else begin
				psg_cnt <= psg_cnt + 1;
			end
		end
	end

endmodule

//--- bench/tb_md_system.sv
`timescale 1ns/1ps

module tb_md_system
	import md_bus_pkg::*;
();

	typedef enum logic [1:0] {
		OP_CPU,
		OP_DMA,
		OP_BOTH
	} op_e;

	// One row of the stimulus table, addresses are byte addresses
	typedef struct packed {
		op_e         op;
		logic [23:0] addr;
		logic        rnw;
		logic [1:0]  be;
		logic [15:0] wdata;
		logic [23:0] dma_addr;
		logic [1:0]  turbo;
		logic [23:0] rom_size;
	} step_t;

	localparam int          RAM_BITS     = 15;
	localparam int          STEPS        = 21;
	localparam int          DONE_TIMEOUT = 200;
	localparam int          CE_TIMEOUT   = 40;
	localparam logic [23:0] ROM_2M       = 24'h200000;
	localparam logic [23:0] ROM_4M       = 24'h400000;

	logic        MCLK;
	logic        reset;
	logic [1:0]  turbo;
	logic        cpu_req;
	bus_req_t    cpu_access;
	logic        dma_req;
	bus_addr_t   dma_addr;
	logic [23:0] rom_size;
	logic        rom_ack;
	bus_data_t   rom_data;
	logic        cpu_done;
	logic        dma_done;
	bus_data_t   rdata;
	logic        rom_req;
	logic [23:0] rom_addr;
	logic        cpu_ce_p;
	logic        cpu_ce_n;
	logic        fm_ce;
	logic        psg_ce;

	step_t      steps [STEPS];
	logic [7:0] ram_hi [2 ** RAM_BITS];
	logic [7:0] ram_lo [2 ** RAM_BITS];
	bank_t      bank_m [8];
	logic       map_m;
	bus_data_t  open_m;
	int         issued;

	md_system #(
		.RAM_ADDR_BITS (RAM_BITS)
	) dut (.*);

	md_bus_checker chk (.*);

	initial begin
		MCLK = 1'b0;
		forever #2 MCLK = ~MCLK;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// ------------------------------------------------------------------------
	// Cartridge ROM model, answers after 0 to 5 cycles
	// ------------------------------------------------------------------------

	initial begin
		logic [31:0] rng;
		int          delay;
		rng      = 32'd31022;
		delay    = -1;
		rom_ack  = 1'b0;
		rom_data = '0;
		forever begin
			@(negedge MCLK);
			if (reset) begin
				rom_ack = 1'b0;
				delay   = -1;
			end else if (rom_req != rom_ack) begin
				if (delay < 0) begin
					rng   = xorshift32(rng);
					delay = int'(rng % 6);
				end
				if (delay == 0) begin
					rom_data = rom_addr[15:0] ^ 16'hA5C3;
					rom_ack  = rom_req;
					delay    = -1;
				end else begin
					delay--;
				end
			end
		end
	end

	// Reference model of one access, queues the expected result
	task automatic model_access(input logic is_dma, input logic [23:0] a, input logic rnw,
			input logic [1:0] be, input bus_data_t wdata);
		logic [RAM_BITS-1:0] idx;
		logic [23:0]         wa;
		bus_data_t           exp;
		idx = a[RAM_BITS:1];
		exp = open_m;
		if (a < 24'hA00000) begin
			if (rnw && a >= rom_size) begin
				exp = '0;
			end else if (rnw) begin
				wa  = map_m ? {1'b0, bank_m[a[21:19]], a[18:1]} : {1'b0, a[23:1]};
				exp = wa[15:0] ^ 16'hA5C3;
				chk.expect_rom_addr(wa);
				if (!is_dma) open_m = exp;
			end
		end else if (a[23:8] == 16'hA130) begin
			if (!rnw && rom_size > ROM_2M && a[3:1] != 3'd0) begin
				bank_m[a[3:1]] = wdata[4:0];
				map_m          = 1'b1;
			end
		end else if (a >= 24'hE00000) begin
			if (rnw) begin
				exp = {ram_hi[idx], ram_lo[idx]};
				if (!is_dma) open_m = exp;
			end else begin
				if (be[1]) ram_hi[idx] = wdata[15:8];
				if (be[0]) ram_lo[idx] = wdata[7:0];
			end
		end
		chk.expect_done(is_dma, exp);
	endtask

	task automatic wait_done(output logic ok);
		int cycles;
		cycles = 0;
		while (chk.seen < issued && cycles < DONE_TIMEOUT) begin
			@(negedge MCLK);
			cycles++;
		end
		ok = chk.seen >= issued;
		if (!ok) chk.note_failure($sformatf("Access %0d got no done strobe in %0d cycles",
			issued, DONE_TIMEOUT));
	endtask

	task automatic apply_step(input step_t s, output logic ok);
		@(negedge MCLK);
		rom_size = s.rom_size;
		if (s.op != OP_DMA) model_access(1'b0, s.addr, s.rnw, s.be, s.wdata);
		if (s.op != OP_CPU) model_access(1'b1, s.dma_addr, 1'b1, 2'b11, '0);
		cpu_req    = s.op != OP_DMA;
		cpu_access = '{addr: s.addr[23:1], wdata: s.wdata, rnw: s.rnw, be: s.be};
		dma_req    = s.op != OP_CPU;
		dma_addr   = s.dma_addr[23:1];
		issued    += (s.op == OP_BOTH) ? 2 : 1;
		@(negedge MCLK);
		cpu_req = 1'b0;
		dma_req = 1'b0;
		wait_done(ok);
	endtask

	// New turbo value, then let the old period run out before measuring
	task automatic check_cpu_period(input logic [1:0] t, output logic ok);
		int start;
		int cycles;
		int expected;
		expected = (t == 2'd1) ? 4 : (t == 2'd2) ? 2 : 7;
		@(negedge MCLK);
		turbo  = t;
		start  = chk.cpu_pulses;
		cycles = 0;
		while (chk.cpu_pulses < start + 3 && cycles < CE_TIMEOUT) begin
			@(negedge MCLK);
			cycles++;
		end
		ok = chk.cpu_pulses >= start + 3;
		if (ok) chk.compare_cpu_gap(expected, t);
		else chk.note_failure($sformatf("cpu_ce_p stopped pulsing with turbo %0d", t));
	endtask

	task automatic load_steps();
		// op      addr        rnw   be     wdata     dma_addr    turbo rom_size
		steps[0]  = '{OP_CPU,  24'hC00000, 1'b1, 2'b11, 16'h0000, 24'h000000, 2'd0, ROM_2M};
		steps[1]  = '{OP_CPU,  24'hFF0010, 1'b0, 2'b11, 16'h1234, 24'h000000, 2'd0, ROM_2M};
		steps[2]  = '{OP_CPU,  24'hFF0010, 1'b0, 2'b10, 16'hAB00, 24'h000000, 2'd0, ROM_2M};
		steps[3]  = '{OP_CPU,  24'hFF0010, 1'b0, 2'b01, 16'h00CD, 24'h000000, 2'd1, ROM_2M};
		steps[4]  = '{OP_CPU,  24'hFF0010, 1'b1, 2'b11, 16'h0000, 24'h000000, 2'd1, ROM_2M};
		steps[5]  = '{OP_CPU,  24'hE10010, 1'b1, 2'b11, 16'h0000, 24'h000000, 2'd1, ROM_2M};
		steps[6]  = '{OP_CPU,  24'hA10000, 1'b1, 2'b11, 16'h0000, 24'h000000, 2'd1, ROM_2M};
		steps[7]  = '{OP_DMA,  24'h000000, 1'b1, 2'b11, 16'h0000, 24'h000200, 2'd1, ROM_2M};
		steps[8]  = '{OP_CPU,  24'hA10002, 1'b1, 2'b11, 16'h0000, 24'h000000, 2'd1, ROM_2M};
		steps[9]  = '{OP_CPU,  24'h012346, 1'b1, 2'b11, 16'h0000, 24'h000000, 2'd2, ROM_2M};
		steps[10] = '{OP_CPU,  24'hA13000, 1'b1, 2'b11, 16'h0000, 24'h000000, 2'd2, ROM_2M};
		steps[11] = '{OP_CPU,  24'h300000, 1'b1, 2'b11, 16'h0000, 24'h000000, 2'd2, ROM_2M};
		steps[12] = '{OP_CPU,  24'hA13006, 1'b0, 2'b11, 16'h0009, 24'h000000, 2'd2, ROM_2M};
		steps[13] = '{OP_CPU,  24'h180010, 1'b1, 2'b11, 16'h0000, 24'h000000, 2'd2, ROM_2M};
		steps[14] = '{OP_CPU,  24'hA13006, 1'b0, 2'b11, 16'h0009, 24'h000000, 2'd2, ROM_4M};
		steps[15] = '{OP_CPU,  24'h180010, 1'b1, 2'b11, 16'h0000, 24'h000000, 2'd2, ROM_4M};
		steps[16] = '{OP_CPU,  24'h300000, 1'b1, 2'b11, 16'h0000, 24'h000000, 2'd2, ROM_4M};
		steps[17] = '{OP_BOTH, 24'h040ABC, 1'b1, 2'b11, 16'h0000, 24'hFF0010, 2'd0, ROM_4M};
		steps[18] = '{OP_DMA,  24'h000000, 1'b1, 2'b11, 16'h0000, 24'hC00000, 2'd0, ROM_4M};
		steps[19] = '{OP_CPU,  24'hC00000, 1'b1, 2'b11, 16'h0000, 24'h000000, 2'd0, ROM_4M};
		steps[20] = '{OP_BOTH, 24'hFF0030, 1'b0, 2'b11, 16'h5A5A, 24'hFF0030, 2'd0, ROM_4M};
	endtask

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------

	initial begin
		logic ok;
		int   turbo_now;
		reset      = 1'b1;
		turbo      = 2'd0;
		cpu_req    = 1'b0;
		cpu_access = '0;
		dma_req    = 1'b0;
		dma_addr   = '0;
		rom_size   = ROM_2M;
		for (int b = 0; b < 8; b++) begin
			bank_m[b] = bank_t'(b);
		end
		map_m     = 1'b0;
		open_m    = 16'h4E71;
		issued    = 0;
		turbo_now = -1;
		ok        = 1'b1;
		load_steps();

		repeat (4) @(negedge MCLK);
		reset = 1'b0;

		for (int i = 0; i < STEPS && ok; i++) begin
			if (int'(steps[i].turbo) != turbo_now) begin
				turbo_now = int'(steps[i].turbo);
				check_cpu_period(steps[i].turbo, ok);
			end
			if (ok) apply_step(steps[i], ok);
		end
		repeat (40) @(negedge MCLK);

		chk.print_summary();
		if (chk.error_total() == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- md_system.f
verilog/md_bus_pkg.sv
verilog/md_clock_enables.sv
verilog/md_addr_decode.sv
verilog/md_bank_mapper.sv
verilog/md_rom_port.sv
verilog/md_work_ram.sv
verilog/md_bus_fsm.sv
verilog/md_system.sv
bench/md_bus_checker.sv
bench/tb_md_system.sv

//--- verilog/md_addr_decode.sv
`timescale 1ns/1ps

module md_addr_decode
	import md_bus_pkg::*;
(
	input  bus_addr_t   addr,
	input  logic [23:0] rom_size,
	output bus_target_e target
);

	logic [23:0] byte_addr;

	assign byte_addr = {addr, 1'b0};

	// ------------------------------------------------------------------------
	// 000000-9FFFFF  cartridge, empty above the ROM size
	// A130xx         bank registers
	// E00000-FFFFFF  work RAM, mirrored
	// ------------------------------------------------------------------------

	always_comb begin
		if (addr[23:20] < 4'hA) begin
			if (byte_addr < rom_size) begin
				target = TGT_ROM;
			end else begin
				target = TGT_ROM_VOID;
			end
		end else if (addr[23:8] == 16'hA130) begin
			target = TGT_BANK_REG;
		end else if (&addr[23:21]) begin
			target = TGT_WORK_RAM;
		end else begin
			// Nothing answers here
			target = TGT_OPEN_BUS;
		end
	end

endmodule

//--- verilog/md_bank_mapper.sv
`timescale 1ns/1ps

module md_bank_mapper
	import md_bus_pkg::*;
(
	input  logic        MCLK,
	input  logic        reset,
	input  logic        bank_wr,
	input  bus_req_t    cur,
	input  logic [23:0] rom_size,
	output logic [23:0] rom_addr
);

	bank_t      bank_reg [BANK_SLOTS];
	logic       map_on;
	logic [2:0] wr_slot;

	assign wr_slot = cur.addr[3:1];

	always_ff @(posedge MCLK) begin
		if (reset) begin
			// Identity map, slot n shows bank n
			for (int i = 0; i < BANK_SLOTS; i++) begin
				bank_reg[i] <= bank_t'(i);
			end
			map_on <= 1'b0;
		end else if (bank_wr && rom_size > ROM_BANK_LIMIT && wr_slot != 3'd0) begin
			// Slot 0 is fixed on SSF2 style carts
			bank_reg[wr_slot] <= cur.wdata[4:0];
			map_on            <= 1'b1;
		end
	end

	// Window select from A21..A19, offset from A18..A1
	always_comb begin
		if (map_on) begin
			rom_addr = {1'b0, bank_reg[cur.addr[21:19]], cur.addr[18:1]};
		end else begin
			rom_addr = {1'b0, cur.addr};
		end
	end

endmodule

//--- verilog/md_bus_fsm.sv
`timescale 1ns/1ps

module md_bus_fsm
	import md_bus_pkg::*;
(
	input  logic        MCLK,
	input  logic        reset,
	input  logic        cpu_req,
	input  bus_req_t    cpu_access,
	input  logic        dma_req,
	input  bus_addr_t   dma_addr,
	input  bus_target_e target,
	input  bus_data_t   ram_q,
	input  logic        rom_done,
	input  bus_data_t   rom_q,
	output bus_req_t    cur,
	output logic        ram_sel,
	output logic        bank_wr,
	output logic        rom_start,
	output logic        cpu_done,
	output logic        dma_done,
	output bus_data_t   rdata
);

	bus_state_e  state;
	bus_master_e owner;
	logic        cpu_pend;
	logic        dma_pend;
	bus_req_t    cpu_acc_q;
	bus_addr_t   dma_addr_q;
	bus_req_t    dma_access;
	bus_data_t   data;
	bus_data_t   open_bus;

	// DMA only ever reads whole words
	assign dma_access = '{addr: dma_addr_q, wdata: '0, rnw: 1'b1, be: 2'b11};

	// ------------------------------------------------------------------------
	// Sequencing, pending flags and the open-bus latch
	// ------------------------------------------------------------------------

	always_ff @(posedge MCLK) begin
		if (reset) begin
			state    <= IDLE;
			owner    <= MST_CPU;
			cpu_pend <= 1'b0;
			dma_pend <= 1'b0;
			open_bus <= OPEN_BUS_RESET;
		end else begin
			if (cpu_req) cpu_pend <= 1'b1;
			if (dma_req) dma_pend <= 1'b1;

			case (state)
				IDLE: begin
					// CPU wins a tie
					if (cpu_pend) begin
						owner    <= MST_CPU;
						cpu_pend <= 1'b0;
						state    <= SELECT;
					end else if (dma_pend) begin
						owner    <= MST_DMA;
						dma_pend <= 1'b0;
						state    <= SELECT;
					end
				end
				SELECT: begin
					case (target)
						TGT_WORK_RAM: state <= RAM_READ;
						TGT_ROM:      state <= cur.rnw ? ROM_WAIT : FINISH;
						default:      state <= FINISH;
					endcase
				end
				RAM_READ: begin
					if (owner == MST_CPU && cur.rnw) open_bus <= ram_q;
					state <= FINISH;
				end
				ROM_WAIT: begin
					if (rom_done) begin
						if (owner == MST_CPU) open_bus <= rom_q;
						state <= FINISH;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Captured access and the result word
	always_ff @(posedge MCLK) begin
		if (cpu_req) cpu_acc_q <= cpu_access;
		if (dma_req) dma_addr_q <= dma_addr;

		case (state)
			IDLE: begin
				if (cpu_pend) cur <= cpu_acc_q;
				else if (dma_pend) cur <= dma_access;
			end
			// Writes and unmapped reads see the latch, empty ROM space reads 0
			SELECT:   data <= (cur.rnw && target == TGT_ROM_VOID) ? '0 : open_bus;
			RAM_READ: if (cur.rnw) data <= ram_q;
			ROM_WAIT: if (rom_done) data <= rom_q;
			default:  ;
		endcase
	end

	assign ram_sel   = state == SELECT && target == TGT_WORK_RAM;
	assign bank_wr   = state == SELECT && target == TGT_BANK_REG && !cur.rnw;
	assign rom_start = state == SELECT && target == TGT_ROM && cur.rnw;

	assign cpu_done = state == FINISH && owner == MST_CPU;
	assign dma_done = state == FINISH && owner == MST_DMA;
	assign rdata    = data;

	a_one_done: assert property (@(posedge MCLK) disable iff (reset)
		!(cpu_done && dma_done));

endmodule

//--- verilog/md_bus_pkg.sv
package md_bus_pkg;

	// ------------------------------------------------------------------------
	// Bus words
	// ------------------------------------------------------------------------

	// 68000 word address, A0 is implied by the byte enables
	typedef logic [23:1] bus_addr_t;
	typedef logic [15:0] bus_data_t;

	// One access as it travels through the bus
	typedef struct packed {
		bus_addr_t addr;
		bus_data_t wdata;
		logic      rnw;
		logic [1:0] be;   // [1] upper byte, [0] lower byte
	} bus_req_t;

	// ------------------------------------------------------------------------
	// Enumerations
	// ------------------------------------------------------------------------

	typedef enum logic [2:0] {
		TGT_ROM,
		TGT_ROM_VOID,
		TGT_BANK_REG,
		TGT_WORK_RAM,
		TGT_OPEN_BUS
	} bus_target_e;

	typedef enum logic [2:0] {
		IDLE,
		SELECT,
		RAM_READ,
		ROM_WAIT,
		FINISH
	} bus_state_e;

	typedef enum logic {
		MST_CPU,
		MST_DMA
	} bus_master_e;

	// ------------------------------------------------------------------------
	// Banking and open bus
	// ------------------------------------------------------------------------

	// 512 KB slot number
	typedef logic [4:0] bank_t;

	localparam int BANK_SLOTS = 8;

	// NOP opcode, what the CPU sees before any real read
	localparam bus_data_t OPEN_BUS_RESET = 16'h4E71;

	// Bank writes only count for carts bigger than 2 MB
	localparam logic [23:0] ROM_BANK_LIMIT = 24'h200000;

	// Clock enable periods in MCLK cycles
	localparam int CPU_PERIOD_NORMAL = 7;
	localparam int CPU_PERIOD_TURBO1 = 4;
	localparam int CPU_PERIOD_TURBO2 = 2;
	localparam int FM_PERIOD         = 7;
	localparam int PSG_PERIOD        = 15;

endpackage

//--- verilog/md_clock_enables.sv
`timescale 1ns/1ps

module md_clock_enables
	import md_bus_pkg::*;
(
	input  logic       MCLK,
	input  logic       reset,
	input  logic [1:0] turbo,
	output logic       cpu_ce_p,
	output logic       cpu_ce_n,
	output logic       fm_ce,
	output logic       psg_ce
);

	logic [3:0] cpu_cnt;
	logic [3:0] cpu_period;
	logic [3:0] next_period;
	logic [3:0] cpu_mid;
	logic [3:0] next_mid;
	logic       cpu_wrap;
	logic [3:0] fm_cnt;
	logic [3:0] psg_cnt;
	logic       fm_wrap;
	logic       psg_wrap;

	always_comb begin
		case (turbo)
			2'd1:    next_period = 4'(CPU_PERIOD_TURBO1);
			2'd2:    next_period = 4'(CPU_PERIOD_TURBO2);
			default: next_period = 4'(CPU_PERIOD_NORMAL);
		endcase
	end

	// Offset of the n phase after the p phase: 3, 1 or 0
	assign cpu_mid  = (cpu_period - 4'd1) >> 1;
	assign next_mid = (next_period - 4'd1) >> 1;
	assign cpu_wrap = cpu_cnt == cpu_period - 4'd1;
	assign fm_wrap  = fm_cnt == 4'(FM_PERIOD - 1);
	assign psg_wrap = psg_cnt == 4'(PSG_PERIOD - 1);

	always_ff @(posedge MCLK) begin
		if (reset) begin
			cpu_cnt    <= '0;
			cpu_period <= 4'(CPU_PERIOD_NORMAL);
			fm_cnt     <= '0;
			psg_cnt    <= '0;
			cpu_ce_p   <= 1'b0;
			cpu_ce_n   <= 1'b0;
			fm_ce      <= 1'b0;
			psg_ce     <= 1'b0;
		end else begin
			// Turbo only changes the period at a wrap
			if (cpu_wrap) begin
				cpu_cnt    <= '0;
				cpu_period <= next_period;
			end else begin
				cpu_cnt <= cpu_cnt + 4'd1;
			end
			cpu_ce_p <= cpu_wrap;
			cpu_ce_n <= cpu_wrap ? (next_mid == 4'd0) : (cpu_cnt + 4'd1 == cpu_mid);

			fm_cnt  <= fm_wrap ? 4'd0 : fm_cnt + 4'd1;
			fm_ce   <= fm_wrap;
			psg_cnt <= psg_wrap ? 4'd0 : psg_cnt + 4'd1;
			psg_ce  <= psg_wrap;
		end
	end

	// Both phases together only in the fastest turbo mode
	a_phase_overlap: assert property (@(posedge MCLK) disable iff (reset)
		(cpu_ce_p && cpu_ce_n) |-> cpu_period == 4'(CPU_PERIOD_TURBO2));

endmodule

//--- verilog/md_rom_port.sv
`timescale 1ns/1ps

module md_rom_port
	import md_bus_pkg::*;
(
	input  logic      MCLK,
	input  logic      reset,
	input  logic      rom_start,
	input  logic      rom_ack,
	input  bus_data_t rom_data,
	output logic      rom_req,
	output logic      rom_done,
	output bus_data_t rom_q
);

	logic busy;
	logic ack_seen;

	// Request is outstanding while req and ack differ
	assign ack_seen = busy && rom_req == rom_ack;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			rom_req  <= 1'b0;
			busy     <= 1'b0;
			rom_done <= 1'b0;
		end else begin
			rom_done <= 1'b0;
			if (rom_start) begin
				rom_req <= ~rom_req;
				busy    <= 1'b1;
			end else if (ack_seen) begin
				busy     <= 1'b0;
				rom_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge MCLK) begin
		if (ack_seen) rom_q <= rom_data;
	end

	a_no_overlap: assert property (@(posedge MCLK) disable iff (reset)
		rom_start |-> !busy);

endmodule

//--- verilog/md_system.sv
`timescale 1ns/1ps

module md_system
	import md_bus_pkg::*;
#(
	parameter int RAM_ADDR_BITS = 15
)
(
	input  logic        MCLK,
	input  logic        reset,
	input  logic [1:0]  turbo,
	input  logic        cpu_req,
	input  bus_req_t    cpu_access,
	input  logic        dma_req,
	input  bus_addr_t   dma_addr,
	input  logic [23:0] rom_size,
	input  logic        rom_ack,
	input  bus_data_t   rom_data,
	output logic        cpu_done,
	output logic        dma_done,
	output bus_data_t   rdata,
	output logic        rom_req,
	output logic [23:0] rom_addr,
	output logic        cpu_ce_p,
	output logic        cpu_ce_n,
	output logic        fm_ce,
	output logic        psg_ce
);

	bus_req_t    cur;
	bus_target_e target;
	bus_data_t   ram_q;
	bus_data_t   rom_q;
	logic        rom_done;
	logic        ram_sel;
	logic        bank_wr;
	logic        rom_start;

	// ------------------------------------------------------------------------
	// Timing
	// ------------------------------------------------------------------------

	md_clock_enables u_ce (
		.MCLK     (MCLK),
		.reset    (reset),
		.turbo    (turbo),
		.cpu_ce_p (cpu_ce_p),
		.cpu_ce_n (cpu_ce_n),
		.fm_ce    (fm_ce),
		.psg_ce   (psg_ce)
	);

	// ------------------------------------------------------------------------
	// Main bus
	// ------------------------------------------------------------------------

	md_bus_fsm u_fsm (
		.MCLK       (MCLK),
		.reset      (reset),
		.cpu_req    (cpu_req),
		.cpu_access (cpu_access),
		.dma_req    (dma_req),
		.dma_addr   (dma_addr),
		.target     (target),
		.ram_q      (ram_q),
		.rom_done   (rom_done),
		.rom_q      (rom_q),
		.cur        (cur),
		.ram_sel    (ram_sel),
		.bank_wr    (bank_wr),
		.rom_start  (rom_start),
		.cpu_done   (cpu_done),
		.dma_done   (dma_done),
		.rdata      (rdata)
	);

	md_addr_decode u_decode (
		.addr     (cur.addr),
		.rom_size (rom_size),
		.target   (target)
	);

	md_bank_mapper u_bank (
		.MCLK     (MCLK),
		.reset    (reset),
		.bank_wr  (bank_wr),
		.cur      (cur),
		.rom_size (rom_size),
		.rom_addr (rom_addr)
	);

	md_rom_port u_rom (
		.MCLK      (MCLK),
		.reset     (reset),
		.rom_start (rom_start),
		.rom_ack   (rom_ack),
		.rom_data  (rom_data),
		.rom_req   (rom_req),
		.rom_done  (rom_done),
		.rom_q     (rom_q)
	);

	md_work_ram #(
		.RAM_ADDR_BITS (RAM_ADDR_BITS)
	) u_ram (
		.MCLK    (MCLK),
		.ram_sel (ram_sel),
		.cur     (cur),
		.q       (ram_q)
	);

endmodule

//--- verilog/md_work_ram.sv
`timescale 1ns/1ps

module md_work_ram
	import md_bus_pkg::*;
#(
	parameter int RAM_ADDR_BITS = 15
)
(
	input  logic      MCLK,
	input  logic      ram_sel,
	input  bus_req_t  cur,
	output bus_data_t q
);

	localparam int WORDS = 2 ** RAM_ADDR_BITS;

	logic [7:0]               mem_hi [WORDS];
	logic [7:0]               mem_lo [WORDS];
	logic [RAM_ADDR_BITS-1:0] idx;
	logic                     wr;

	// Upper address bits are ignored, so the RAM repeats over its region
	assign idx = cur.addr[RAM_ADDR_BITS:1];
	assign wr  = ram_sel && !cur.rnw;

	always_ff @(posedge MCLK) begin
		if (wr && cur.be[1]) mem_hi[idx] <= cur.wdata[15:8];
		if (wr && cur.be[0]) mem_lo[idx] <= cur.wdata[7:0];
		if (ram_sel) q <= {mem_hi[idx], mem_lo[idx]};
	end

endmodule
